// ==== Makefile ====
# Verilator flow for the byte FIFO testbench

TOP := byteFifoTb

.PHONY: all lint clean

# build, run, and pass only when the pass message shows up
all:
	verilator --binary --assert --timing -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --assert --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== rtl/byteFifo.sv ====
// byteFifo top module joining the write stage, the dual-port storage and the read stage
`timescale 1ns/100ps

module byteFifo (
   input  logic                           Rclk,
   input  logic                           reset,      // sync, active high
   input  logic                           wrStrobe,   // push dataIn
   input  logic [fifoPkg::DataWidth-1:0]  dataIn,
   input  logic                           rdStrobe,   // pop one byte
   output logic [fifoPkg::DataWidth-1:0]  dataOut,    // idle value unless dataValid
   output logic                           dataValid,
   output logic                           full,
   output logic                           empty,
   output logic                           overflow,   // refused write seen
   output logic                           underflow   // refused read seen
);

   import fifoPkg::*;

   logic [PtrWidth-1:0] wrPtr;                        // writer side, with wrap bit
   logic [PtrWidth-1:0] rdPtr;                        // reader side, with wrap bit
   logic                memWen;
   logic                memRen;

   // write stage
   fifoWriter uWriter (
      .Rclk      (Rclk),
      .reset     (reset),
      .wrStrobe  (wrStrobe),
      .rdPtr     (rdPtr),
      .wrPtr     (wrPtr),
      .memWen    (memWen),
      .full      (full),
      .overflow  (overflow)
   );

   // storage, addressed by the low pointer bits
   dualPortMem uMem (
      .Rclk      (Rclk),
      .wen       (memWen),
      .wrAddr    (wrPtr[AddrWidth-1:0]),
      .dataIn    (dataIn),
      .ren       (memRen),
      .rdAddr    (rdPtr[AddrWidth-1:0]),
      .dataOut   (dataOut)
   );

   // read stage
   fifoReader uReader (
      .Rclk      (Rclk),
      .reset     (reset),
      .rdStrobe  (rdStrobe),
      .wrPtr     (wrPtr),
      .rdPtr     (rdPtr),
      .memRen    (memRen),
      .dataValid (dataValid),
      .empty     (empty),
      .underflow (underflow)
   );

endmodule : byteFifo

// ==== rtl/dualPortMem.sv ====
// dualPortMem module with synchronous write port and registered read port with idle output
`timescale 1ns/100ps

module dualPortMem (
   input  logic                           Rclk,
   input  logic                           wen,        // write this cycle
   input  logic [fifoPkg::AddrWidth-1:0]  wrAddr,
   input  logic [fifoPkg::DataWidth-1:0]  dataIn,
   input  logic                           ren,        // read this cycle
   input  logic [fifoPkg::AddrWidth-1:0]  rdAddr,
   output logic [fifoPkg::DataWidth-1:0]  dataOut     // registered, one cycle after ren
);

   import fifoPkg::*;

   logic [DataWidth-1:0] storage [Depth];             // byte array, contents not cleared

   // write port
   always_ff @(posedge Rclk)
   begin
      if (wen)
      begin
         storage[wrAddr] <= dataIn;
      end
   end

   // read port shows the idle value on every cycle without a read
   always_ff @(posedge Rclk)
   begin
      if (ren)
      begin
         dataOut <= storage[rdAddr];                  // addressed entry
      end
      else
      begin
         dataOut <= IdleOutput;                       // idle pattern
      end
   end

   // enabled ports need clean addresses
   wrAddrKnown : assert property (@(posedge Rclk)
      wen |-> !$isunknown(wrAddr))
      else $error("unknown write address with wen high");

   rdAddrKnown : assert property (@(posedge Rclk)
      ren |-> !$isunknown(rdAddr))
      else $error("unknown read address with ren high");

endmodule : dualPortMem

// ==== rtl/fifoPkg.sv ====
// package fifoPkg with the byte width, address width, depth, pointer width and idle read value

package fifoPkg;

   // storage geometry
   localparam int DataWidth = 8;                      // one stored byte
   localparam int AddrWidth = 4;                      // memory address bits
   localparam int Depth     = 1 << AddrWidth;         // 16 entries

   // pointers carry one extra wrap bit
   // equal low bits plus different wrap bits means full
   // fully equal pointers means empty
   localparam int PtrWidth  = AddrWidth + 1;

   // value on the read port whenever no read is done
   localparam logic [DataWidth-1:0] IdleOutput = '0;

endpackage : fifoPkg

// ==== rtl/fifoReader.sv ====
// fifoReader module with read pointer, empty level, sticky underflow, read enable and valid pulse
`timescale 1ns/100ps

module fifoReader (
   input  logic                          Rclk,
   input  logic                          reset,      // sync, active high
   input  logic                          rdStrobe,   // one-cycle pop request
   input  logic [fifoPkg::PtrWidth-1:0]  wrPtr,      // from write stage
   output logic [fifoPkg::PtrWidth-1:0]  rdPtr,      // next slot to read
   output logic                          memRen,     // accepted read
   output logic                          dataValid,  // dataOut holds a byte
   output logic                          empty,
   output logic                          underflow   // sticky until reset
);

   import fifoPkg::*;

   logic [PtrWidth-1:0] fillLevel;                    // bytes held, 0 to Depth

   assign empty     = (rdPtr == wrPtr);               // pointers seen before the edge
   assign fillLevel = wrPtr - rdPtr;                  // modulo wrap is intended

   // a read while empty is refused, even with a write in the same cycle
   assign memRen = rdStrobe && !empty;

   always_ff @(posedge Rclk)
   begin
      if (reset)
      begin
         rdPtr     <= '0;
         dataValid <= 1'b0;
         underflow <= 1'b0;
      end
      else
      begin
         dataValid <= memRen;                         // lines up with the memory output reg
         if (memRen)
         begin
            rdPtr <= rdPtr + PtrWidth'(1);            // move on to next byte
         end
         if (rdStrobe && empty)
         begin
            underflow <= 1'b1;                        // no pulse, flag stays
         end
      end
   end

   // reader stays at most one lap behind the writer
   noPassWriter : assert property (@(posedge Rclk) disable iff (reset)
      fillLevel <= PtrWidth'(Depth))
      else $error("read pointer passed write pointer");

endmodule : fifoReader

// ==== rtl/fifoWriter.sv ====
// fifoWriter module with write pointer, full level, sticky overflow and memory write enable
`timescale 1ns/100ps

module fifoWriter (
   input  logic                          Rclk,
   input  logic                          reset,      // sync, active high
   input  logic                          wrStrobe,   // one-cycle push request
   input  logic [fifoPkg::PtrWidth-1:0]  rdPtr,      // from read stage
   output logic [fifoPkg::PtrWidth-1:0]  wrPtr,      // next slot to write
   output logic                          memWen,     // accepted write
   output logic                          full,
   output logic                          overflow    // sticky until reset
);

   import fifoPkg::*;

   logic lowMatch;                                    // same memory slot
   logic wrapDiffer;                                  // writer one lap ahead

   assign lowMatch   = (wrPtr[AddrWidth-1:0] == rdPtr[AddrWidth-1:0]);
   assign wrapDiffer = (wrPtr[AddrWidth] != rdPtr[AddrWidth]);
   assign full       = lowMatch && wrapDiffer;        // pointers seen before the edge

   // a write while full is dropped, even with a read in the same cycle
   assign memWen = wrStrobe && !full;

   always_ff @(posedge Rclk)
   begin
      if (reset)
      begin
         wrPtr    <= '0;                              // start at slot zero
         overflow <= 1'b0;
      end
      else
      begin
         if (memWen)
         begin
            wrPtr <= wrPtr + PtrWidth'(1);            // wraps through the extra bit
         end
         if (wrStrobe && full)
         begin
            overflow <= 1'b1;                         // byte lost, flag stays
         end
      end
   end

   // full only holds if the reader steps at most one slot per edge
   readerStep : assert property (@(posedge Rclk) disable iff (reset)
      (rdPtr == $past(rdPtr)) || (rdPtr == $past(rdPtr) + PtrWidth'(1)))
      else $error("read pointer moved by more than one slot");

endmodule : fifoWriter

// ==== sim.f ====
+incdir+verification
rtl/fifoPkg.sv
rtl/fifoWriter.sv
rtl/dualPortMem.sv
rtl/fifoReader.sv
rtl/byteFifo.sv
verification/byteFifoTb.sv

// ==== verification/fifoRefModel.svh ====
// reference model function for the byte FIFO and the value compare task
`ifndef FIFO_REF_MODEL_SVH
`define FIFO_REF_MODEL_SVH

typedef logic [DataWidth-1:0] byteQueue [$];          // modeled contents, oldest first

// one rising edge of the FIFO rules, levels taken from the contents before the edge
function automatic void predictEdge(
   input  byteQueue             qIn,                  // contents before the edge
   input  logic                 overflowIn,
   input  logic                 underflowIn,
   input  logic                 wr,                   // strobes sampled at the edge
   input  logic                 rd,
   input  logic [DataWidth-1:0] din,
   output byteQueue             qOut,                 // contents after the edge
   output logic                 expFull,              // levels before the edge
   output logic                 expEmpty,
   output logic                 nextValid,            // outputs after the edge
   output logic [DataWidth-1:0] nextByte,
   output logic                 nextOverflow,
   output logic                 nextUnderflow
);
   qOut          = qIn;
   expFull       = (qIn.size() == Depth);
   expEmpty      = (qIn.size() == 0);
   nextValid     = rd && !expEmpty;                   // empty read gives no pulse
   nextByte      = IdleOutput;                        // idle unless a byte leaves
   nextOverflow  = overflowIn || (wr && expFull);     // sticky
   nextUnderflow = underflowIn || (rd && expEmpty);   // sticky
   if (nextValid)
   begin
      nextByte = qOut.pop_front();                    // oldest byte first
   end
   if (wr && !expFull)
   begin
      qOut.push_back(din);                            // refused byte is simply lost
   end
endfunction

// compares one DUT value with its expected value
task automatic compareValue(input string what, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] expected);
   checkCount++;
   if (got !== expected)
   begin
      errorCount++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, expected);
   end
endtask

`endif

// ==== verification/byteFifoTb.sv ====
// byteFifoTb testbench module with clock, reset, stimulus, compare process and watchdog
`timescale 1ns/100ps

module byteFifoTb;

   import fifoPkg::*;

   localparam int ClockPeriod  = 40;                  // ns
   localparam int ResetCycles  = 5;
   localparam int RandomCycles = 2000;
   localparam int PhaseLength  = 100;                 // cycles per random bias phase

   // reset, idle, fill, drain, empty read, both strobes, settle, random, tail
   localparam int ScheduledCycles = ResetCycles + 2 + (Depth + 1) + Depth + 1 + 1 + 3
                                    + RandomCycles + 4;

   // DUT inputs start at known values
   logic                 Rclk     = 1'b0;
   logic                 reset    = 1'b1;
   logic                 wrStrobe = 1'b0;
   logic [DataWidth-1:0] dataIn   = '0;
   logic                 rdStrobe = 1'b0;

   // DUT outputs
   logic [DataWidth-1:0] dataOut;
   logic                 dataValid;
   logic                 full;
   logic                 empty;
   logic                 overflow;
   logic                 underflow;

   int                   errorCount = 0;
   int                   checkCount = 0;

   `include "fifoRefModel.svh"

   // model state, valid between two negative edges
   byteQueue             modelQueue;
   byteQueue             nextQueue;
   logic                 expValid;
   logic [DataWidth-1:0] expByte;
   logic                 expOverflow;
   logic                 expUnderflow;
   logic                 expFull;
   logic                 expEmpty;
   logic                 nextValid;
   logic [DataWidth-1:0] nextByte;
   logic                 nextOverflow;
   logic                 nextUnderflow;

   byteFifo uut (
      .Rclk      (Rclk),
      .reset     (reset),
      .wrStrobe  (wrStrobe),
      .dataIn    (dataIn),
      .rdStrobe  (rdStrobe),
      .dataOut   (dataOut),
      .dataValid (dataValid),
      .full      (full),
      .empty     (empty),
      .overflow  (overflow),
      .underflow (underflow)
   );

   initial
   begin
      forever
      begin
         #(ClockPeriod / 2) Rclk = ~Rclk;             // first rising edge at 20 ns
      end
   end

   // sets the strobes and byte seen at the next rising edge
   task automatic driveCycle(input logic wr, input logic rd, input logic [DataWidth-1:0] din);
      @(posedge Rclk);
      wrStrobe <= wr;
      rdStrobe <= rd;
      dataIn   <= din;
   endtask

   initial
   begin
      int writeBias;                                  // percent, flips every phase
      void'($urandom(46251));
      repeat (ResetCycles) @(posedge Rclk);
      reset <= 1'b0;
      repeat (2) driveCycle(1'b0, 1'b0, '0);          // quiet state after reset
      for (int i = 0; i <= Depth; i++)
      begin
         // last write hits a full FIFO, marked byte
         driveCycle(1'b1, 1'b0, (i == Depth) ? 8'hEE : DataWidth'(i * 7 + 3));
      end
      for (int i = 0; i < Depth; i++)
      begin
         driveCycle(1'b0, 1'b1, '0);                  // back-to-back drain
      end
      driveCycle(1'b0, 1'b1, '0);                     // read while empty
      driveCycle(1'b1, 1'b1, 8'h5A);                  // both strobes while empty
      repeat (3) driveCycle(1'b0, 1'b0, '0);
      for (int c = 0; c < RandomCycles; c++)
      begin
         writeBias = (((c / PhaseLength) % 2) == 1) ? 80 : 20;   // push toward full, then empty
         driveCycle($urandom_range(99) < writeBias,
                    $urandom_range(99) < (100 - writeBias),
                    DataWidth'($urandom()));
      end
      repeat (4) driveCycle(1'b0, 1'b0, '0);          // let last reads come out
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

   // outputs are stable at the falling edge, strobes too
   always @(negedge Rclk)
   begin
      if (reset)
      begin
         modelQueue.delete();                         // state after the reset edge
         expValid     = 1'b0;
         expByte      = IdleOutput;
         expOverflow  = 1'b0;
         expUnderflow = 1'b0;
      end
      else
      begin
         predictEdge(modelQueue, expOverflow, expUnderflow, wrStrobe, rdStrobe, dataIn,
                     nextQueue, expFull, expEmpty, nextValid, nextByte,
                     nextOverflow, nextUnderflow);
         compareValue("full", DataWidth'(full), DataWidth'(expFull));
         compareValue("empty", DataWidth'(empty), DataWidth'(expEmpty));
         compareValue("dataValid", DataWidth'(dataValid), DataWidth'(expValid));
         compareValue("dataOut", dataOut, expByte);   // idle value checked too
         compareValue("overflow", DataWidth'(overflow), DataWidth'(expOverflow));
         compareValue("underflow", DataWidth'(underflow), DataWidth'(expUnderflow));
         modelQueue   = nextQueue;                    // advance to after the next edge
         expValid     = nextValid;
         expByte      = nextByte;
         expOverflow  = nextOverflow;
         expUnderflow = nextUnderflow;
      end
   end

   // watchdog, twice the scheduled length
   initial
   begin
      #(2 * ScheduledCycles * ClockPeriod);
      $display("Timeout: the test sequence did not finish within %0d clock cycles",
               2 * ScheduledCycles);
      $display("Done: errors found");
      $finish;
   end

endmodule : byteFifoTb
